// File: DaqSystem.f
+incdir+include
hw/DaqDataPkg.sv
hw/DaqCtrlPkg.sv
hw/AutoDaq.sv
hw/SlaveDaq.sv
hw/DaqSwitcher.sv
hw/ChipReadout.sv
hw/DaqSystem.sv
verification/DaqSystem_assertions.sv
verification/DaqSystemTb.sv

// File: hw/AutoDaq.sv
`timescale 1ns/1ps
`include "DaqSystem_consts.svh"

module AutoDaq
    import DaqCtrlPkg::*, DaqDataPkg::*;
(
    input  logic       Clk,
    input  logic       arstN,
    input  logic       Start,
    input  CycleCountT CycleCount,
    input  logic       ChipSatB,
    input  logic       EndReadout,
    input  logic       DataTransmitDone,
    output logic       PwrOnA,
    output logic       PwrOnD,
    output logic       PwrOnAdc,
    output logic       PwrOnDac,
    output logic       ResetB,
    output logic       StartAcq,
    output logic       StartReadout,
    output logic       OnceEnd,
    output logic       AllDone,
    output logic       UsbStartStop
);

    AutoStateT  state;
    AutoStateT  nextState;
    DurationT   durCnt;
    CycleCountT remaining;
    logic       startD;
    logic       startRise;
    logic       settleDone;
    logic       resetDone;
    logic       windowDone;
    logic       powerOn;

    assign startRise  = Start && !startD;
    assign settleDone = durCnt == DurationT'(`PWR_SETTLE - 1);
    assign resetDone  = durCnt == DurationT'(`RESET_CYCLES - 1);
    // Saturation cuts the window short
    assign windowDone = (durCnt == DurationT'(`ACQ_WINDOW - 1)) || !ChipSatB;

    //////////////////////////////////////////////////////////////////////
    // Next state
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        nextState = state;
        case (state)
            AutoIdle:      if (startRise) nextState = AutoPowerUp;
            AutoPowerUp:   if (settleDone) nextState = AutoReset;
            AutoReset:     if (resetDone) nextState = AutoAcquire;
            AutoAcquire:   if (windowDone) nextState = AutoReadout;
            AutoReadout:   if (EndReadout) nextState = AutoTransmit;
            AutoTransmit:  if (DataTransmitDone) nextState = AutoPowerDown;
            // Stop request only takes effect here, at the end of a cycle
            AutoPowerDown: begin
                if (Start && remaining > CycleCountT'(1)) begin
                    nextState = AutoPowerUp;
                end else begin
                    nextState = AutoIdle;
                end
            end
            default:       nextState = AutoIdle;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // State, counters and status pulses
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            state        <= AutoIdle;
            durCnt       <= '0;
            remaining    <= '0;
            startD       <= 1'b0;
            StartReadout <= 1'b0;
            OnceEnd      <= 1'b0;
            AllDone      <= 1'b0;
        end else begin
            state  <= nextState;
            startD <= Start;
            // Restart the duration count on every state change
            durCnt <= (nextState != state) ? '0 : durCnt + 1'b1;

            if (state == AutoIdle && startRise) begin
                remaining <= CycleCount;
            end else if (state == AutoPowerDown && nextState == AutoPowerUp) begin
                remaining <= remaining - 1'b1;
            end

            StartReadout <= (state == AutoAcquire) && (nextState == AutoReadout);
            OnceEnd      <= (state == AutoTransmit) && (nextState == AutoPowerDown);
            AllDone      <= (state == AutoPowerDown) && (nextState == AutoIdle);
        end
    end

    // Power is pulsed off in PowerDown between cycles
    assign powerOn = state inside {AutoPowerUp, AutoReset, AutoAcquire,
                                   AutoReadout, AutoTransmit};

    assign PwrOnA       = powerOn;
    assign PwrOnD       = powerOn;
    assign PwrOnAdc     = powerOn;
    assign PwrOnDac     = powerOn;
    assign ResetB       = state != AutoReset;
    assign StartAcq     = state == AutoAcquire;
    assign UsbStartStop = state != AutoIdle;

endmodule

// File: hw/ChipReadout.sv
`timescale 1ns/1ps

module ChipReadout
    import DaqDataPkg::*;
(
    input  logic      Clk,
    input  logic      arstN,
    input  logic      StartAcq,
    input  logic      ChipHit,
    input  logic      StartReadout,
    output EventWordT DataWord,
    output logic      DataValid,
    output logic      EndReadout,
    output logic      DataTransmitDone
);

    HitCountT hitCount;
    SerialT   serial;
    logic     startAcqD;
    logic     acqRise;
    logic     wordPulse;

    assign acqRise = StartAcq && !startAcqD;

    //////////////////////////////////////////////////////////////////////
    // Hit counter and serial
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            startAcqD        <= 1'b0;
            hitCount         <= '0;
            serial           <= '0;
            wordPulse        <= 1'b0;
            DataTransmitDone <= 1'b0;
        end else begin
            startAcqD <= StartAcq;

            // Fresh count per window, first cycle included
            if (acqRise) begin
                hitCount <= HitCountT'(ChipHit);
            end else if (StartAcq && ChipHit && hitCount != '1) begin
                hitCount <= hitCount + 1'b1;
            end

            wordPulse        <= StartReadout;
            DataTransmitDone <= wordPulse;

            // Next readout number once the word is out
            if (DataTransmitDone) begin
                serial <= serial + 1'b1;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (StartReadout) begin
            DataWord <= {serial, hitCount};
        end
    end

    // Word valid and end of readout come together
    assign DataValid  = wordPulse;
    assign EndReadout = wordPulse;

endmodule

// File: hw/DaqCtrlPkg.sv
`include "DaqSystem_consts.svh"

package DaqCtrlPkg;

    // Counts cycles spent in a timed sequencer state
    typedef logic [`DUR_WIDTH-1:0] DurationT;

    // Power pulsed, self running sequencer
    typedef enum logic [2:0] {
        AutoIdle,
        AutoPowerUp,
        AutoReset,
        AutoAcquire,
        AutoReadout,
        AutoTransmit,
        AutoPowerDown
    } AutoStateT;

    // Trigger driven sequencer, chip stays powered while armed
    typedef enum logic [2:0] {
        SlaveIdle,
        SlaveArmed,
        SlaveReset,
        SlaveAcquire,
        SlaveReadout,
        SlaveTransmit
    } SlaveStateT;

endpackage

// File: hw/DaqDataPkg.sv
`include "DaqSystem_consts.svh"

package DaqDataPkg;

    // Hits seen in one acquisition window
    typedef logic [`HIT_WIDTH-1:0] HitCountT;

    // Running readout number
    typedef logic [`SERIAL_WIDTH-1:0] SerialT;

    // Number of cycles requested over USB
    typedef logic [`CYCLE_WIDTH-1:0] CycleCountT;

    // Serial in the upper part, hit count in the lower part
    typedef logic [`SERIAL_WIDTH+`HIT_WIDTH-1:0] EventWordT;

endpackage

// File: hw/DaqSwitcher.sv
`timescale 1ns/1ps

module DaqSwitcher (
    // High selects the auto sequencer
    input  logic DaqSelect,
    // Chip pins
    input  logic AutoPwrOnA, AutoPwrOnD, AutoPwrOnAdc, AutoPwrOnDac,
    input  logic SlavePwrOnA, SlavePwrOnD, SlavePwrOnAdc, SlavePwrOnDac,
    input  logic AutoResetB, SlaveResetB,
    input  logic AutoStartAcq, SlaveStartAcq,
    output logic PwrOnA, PwrOnD, PwrOnAdc, PwrOnDac,
    output logic ResetB,
    output logic StartAcq,
    // Sequencer status
    input  logic AutoStartReadout, SlaveStartReadout,
    input  logic AutoOnceEnd, SlaveOnceEnd,
    input  logic AutoAllDone, SlaveAllDone,
    input  logic AutoUsbStartStop, SlaveUsbStartStop,
    output logic StartReadout,
    output logic OnceEnd,
    output logic AllDone,
    output logic UsbStartStop,
    // Shared inputs steered back to one side
    input  logic ChipSatB,
    input  logic UsbAcqStart,
    input  logic EndReadout,
    input  logic DataTransmitDone,
    input  logic ExternalTrigger,
    output logic AutoChipSatB, SlaveChipSatB,
    output logic AutoStart, SlaveStart,
    output logic AutoEndReadout, SlaveEndReadout,
    output logic AutoDataTransmitDone, SlaveDataTransmitDone,
    output logic SingleStart
);

    assign PwrOnA       = DaqSelect ? AutoPwrOnA       : SlavePwrOnA;
    assign PwrOnD       = DaqSelect ? AutoPwrOnD       : SlavePwrOnD;
    assign PwrOnAdc     = DaqSelect ? AutoPwrOnAdc     : SlavePwrOnAdc;
    assign PwrOnDac     = DaqSelect ? AutoPwrOnDac     : SlavePwrOnDac;
    assign ResetB       = DaqSelect ? AutoResetB       : SlaveResetB;
    assign StartAcq     = DaqSelect ? AutoStartAcq     : SlaveStartAcq;
    assign StartReadout = DaqSelect ? AutoStartReadout : SlaveStartReadout;
    assign OnceEnd      = DaqSelect ? AutoOnceEnd      : SlaveOnceEnd;
    assign AllDone      = DaqSelect ? AutoAllDone      : SlaveAllDone;
    assign UsbStartStop = DaqSelect ? AutoUsbStartStop : SlaveUsbStartStop;

    // Idle side sees no saturation
    assign AutoChipSatB  = DaqSelect ? ChipSatB : 1'b1;
    assign SlaveChipSatB = DaqSelect ? 1'b1 : ChipSatB;

    assign AutoStart             = DaqSelect ? UsbAcqStart : 1'b0;
    assign SlaveStart            = DaqSelect ? 1'b0 : UsbAcqStart;
    assign AutoEndReadout        = DaqSelect ? EndReadout : 1'b0;
    assign SlaveEndReadout       = DaqSelect ? 1'b0 : EndReadout;
    assign AutoDataTransmitDone  = DaqSelect ? DataTransmitDone : 1'b0;
    assign SlaveDataTransmitDone = DaqSelect ? 1'b0 : DataTransmitDone;

    // Trigger is meaningless in auto mode
    assign SingleStart = DaqSelect ? 1'b0 : ExternalTrigger;

endmodule

// File: hw/DaqSystem.sv
`timescale 1ns/1ps

module DaqSystem
    import DaqDataPkg::*;
(
    input  logic       Clk,
    input  logic       arstN,
    input  logic       DaqSelect,
    input  logic       UsbAcqStart,
    input  CycleCountT CycleCount,
    input  logic       ExternalTrigger,
    input  logic       ChipSatB,
    input  logic       ChipHit,
    output logic       PwrOnA,
    output logic       PwrOnD,
    output logic       PwrOnAdc,
    output logic       PwrOnDac,
    output logic       ResetB,
    output logic       StartAcq,
    output EventWordT  DataWord,
    output logic       DataValid,
    output logic       OnceEnd,
    output logic       AllDone,
    output logic       UsbStartStop
);

    // Auto side
    logic autoPwrOnA, autoPwrOnD, autoPwrOnAdc, autoPwrOnDac;
    logic autoResetB, autoStartAcq, autoStartReadout;
    logic autoOnceEnd, autoAllDone, autoUsbStartStop;
    logic autoChipSatB, autoStart, autoEndReadout, autoDataTransmitDone;

    // Slave side
    logic slavePwrOnA, slavePwrOnD, slavePwrOnAdc, slavePwrOnDac;
    logic slaveResetB, slaveStartAcq, slaveStartReadout;
    logic slaveOnceEnd, slaveAllDone, slaveUsbStartStop;
    logic slaveChipSatB, slaveStart, slaveEndReadout, slaveDataTransmitDone;
    logic singleStart;

    // Readout handshake pulses
    logic startReadout;
    logic endReadout;
    logic dataTransmitDone;

    //////////////////////////////////////////////////////////////////////
    // Sequencers
    //////////////////////////////////////////////////////////////////////
    AutoDaq i_AutoDaq (
        .Clk(Clk), .arstN(arstN),
        .Start(autoStart), .CycleCount(CycleCount), .ChipSatB(autoChipSatB),
        .EndReadout(autoEndReadout), .DataTransmitDone(autoDataTransmitDone),
        .PwrOnA(autoPwrOnA), .PwrOnD(autoPwrOnD),
        .PwrOnAdc(autoPwrOnAdc), .PwrOnDac(autoPwrOnDac),
        .ResetB(autoResetB), .StartAcq(autoStartAcq),
        .StartReadout(autoStartReadout), .OnceEnd(autoOnceEnd),
        .AllDone(autoAllDone), .UsbStartStop(autoUsbStartStop)
    );

    SlaveDaq i_SlaveDaq (
        .Clk(Clk), .arstN(arstN),
        .Start(slaveStart), .SingleStart(singleStart), .ChipSatB(slaveChipSatB),
        .EndReadout(slaveEndReadout), .DataTransmitDone(slaveDataTransmitDone),
        .PwrOnA(slavePwrOnA), .PwrOnD(slavePwrOnD),
        .PwrOnAdc(slavePwrOnAdc), .PwrOnDac(slavePwrOnDac),
        .ResetB(slaveResetB), .StartAcq(slaveStartAcq),
        .StartReadout(slaveStartReadout), .OnceEnd(slaveOnceEnd),
        .AllDone(slaveAllDone), .UsbStartStop(slaveUsbStartStop)
    );

    //////////////////////////////////////////////////////////////////////
    // Pin and status steering
    //////////////////////////////////////////////////////////////////////
    DaqSwitcher i_DaqSwitcher (
        .DaqSelect(DaqSelect),
        .AutoPwrOnA(autoPwrOnA), .AutoPwrOnD(autoPwrOnD),
        .AutoPwrOnAdc(autoPwrOnAdc), .AutoPwrOnDac(autoPwrOnDac),
        .SlavePwrOnA(slavePwrOnA), .SlavePwrOnD(slavePwrOnD),
        .SlavePwrOnAdc(slavePwrOnAdc), .SlavePwrOnDac(slavePwrOnDac),
        .AutoResetB(autoResetB), .SlaveResetB(slaveResetB),
        .AutoStartAcq(autoStartAcq), .SlaveStartAcq(slaveStartAcq),
        .PwrOnA(PwrOnA), .PwrOnD(PwrOnD), .PwrOnAdc(PwrOnAdc), .PwrOnDac(PwrOnDac),
        .ResetB(ResetB), .StartAcq(StartAcq),
        .AutoStartReadout(autoStartReadout), .SlaveStartReadout(slaveStartReadout),
        .AutoOnceEnd(autoOnceEnd), .SlaveOnceEnd(slaveOnceEnd),
        .AutoAllDone(autoAllDone), .SlaveAllDone(slaveAllDone),
        .AutoUsbStartStop(autoUsbStartStop), .SlaveUsbStartStop(slaveUsbStartStop),
        .StartReadout(startReadout), .OnceEnd(OnceEnd),
        .AllDone(AllDone), .UsbStartStop(UsbStartStop),
        .ChipSatB(ChipSatB), .UsbAcqStart(UsbAcqStart),
        .EndReadout(endReadout), .DataTransmitDone(dataTransmitDone),
        .ExternalTrigger(ExternalTrigger),
        .AutoChipSatB(autoChipSatB), .SlaveChipSatB(slaveChipSatB),
        .AutoStart(autoStart), .SlaveStart(slaveStart),
        .AutoEndReadout(autoEndReadout), .SlaveEndReadout(slaveEndReadout),
        .AutoDataTransmitDone(autoDataTransmitDone),
        .SlaveDataTransmitDone(slaveDataTransmitDone),
        .SingleStart(singleStart)
    );

    ChipReadout i_ChipReadout (
        .Clk(Clk), .arstN(arstN),
        .StartAcq(StartAcq), .ChipHit(ChipHit), .StartReadout(startReadout),
        .DataWord(DataWord), .DataValid(DataValid),
        .EndReadout(endReadout), .DataTransmitDone(dataTransmitDone)
    );

endmodule

// File: hw/SlaveDaq.sv
`timescale 1ns/1ps
`include "DaqSystem_consts.svh"

module SlaveDaq
    import DaqCtrlPkg::*;
(
    input  logic Clk,
    input  logic arstN,
    input  logic Start,
    input  logic SingleStart,
    input  logic ChipSatB,
    input  logic EndReadout,
    input  logic DataTransmitDone,
    output logic PwrOnA,
    output logic PwrOnD,
    output logic PwrOnAdc,
    output logic PwrOnDac,
    output logic ResetB,
    output logic StartAcq,
    output logic StartReadout,
    output logic OnceEnd,
    output logic AllDone,
    output logic UsbStartStop
);

    SlaveStateT state;
    SlaveStateT nextState;
    DurationT   durCnt;
    logic       resetDone;
    logic       windowDone;
    logic       powerOn;

    assign resetDone  = durCnt == DurationT'(`RESET_CYCLES - 1);
    assign windowDone = (durCnt == DurationT'(`ACQ_WINDOW - 1)) || !ChipSatB;

    //////////////////////////////////////////////////////////////////////
    // Next state
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        nextState = state;
        case (state)
            SlaveIdle:     if (Start) nextState = SlaveArmed;
            // Triggers only count here, so those inside a cycle are dropped
            SlaveArmed: begin
                if (!Start) begin
                    nextState = SlaveIdle;
                end else if (SingleStart) begin
                    nextState = SlaveReset;
                end
            end
            SlaveReset:    if (resetDone) nextState = SlaveAcquire;
            SlaveAcquire:  if (windowDone) nextState = SlaveReadout;
            SlaveReadout:  if (EndReadout) nextState = SlaveTransmit;
            SlaveTransmit: if (DataTransmitDone) nextState = SlaveArmed;
            default:       nextState = SlaveIdle;
        endcase
    end

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            state        <= SlaveIdle;
            durCnt       <= '0;
            StartReadout <= 1'b0;
            OnceEnd      <= 1'b0;
            AllDone      <= 1'b0;
        end else begin
            state        <= nextState;
            durCnt       <= (nextState != state) ? '0 : durCnt + 1'b1;
            StartReadout <= (state == SlaveAcquire) && (nextState == SlaveReadout);
            OnceEnd      <= (state == SlaveTransmit) && (nextState == SlaveArmed);
            AllDone      <= (state == SlaveArmed) && (nextState == SlaveIdle);
        end
    end

    // Chip stays powered for the whole run
    assign powerOn = state != SlaveIdle;

    assign PwrOnA       = powerOn;
    assign PwrOnD       = powerOn;
    assign PwrOnAdc     = powerOn;
    assign PwrOnDac     = powerOn;
    assign ResetB       = state != SlaveReset;
    assign StartAcq     = state == SlaveAcquire;
    assign UsbStartStop = powerOn;

endmodule

// File: include/DaqSystem_consts.svh
`ifndef DAQSYSTEM_CONSTS_SVH
`define DAQSYSTEM_CONSTS_SVH

// Data widths
`define HIT_WIDTH    8
`define SERIAL_WIDTH 8
`define CYCLE_WIDTH  8

// Sequencer durations in clock cycles
`define PWR_SETTLE   16
`define RESET_CYCLES 4
`define ACQ_WINDOW   32

// Duration counter, must hold the longest of the durations above
`define DUR_WIDTH    6

`endif

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f DaqSystem.f --top-module DaqSystemTb

output="$(./obj_dir/VDaqSystemTb 2>&1 || true)"
echo "$output"

if echo "$output" | grep -qx "No errors"; then
    exit 0
else
    exit 1
fi

// File: verification/DaqSystemTb.sv
`timescale 1ns/1ps
`include "DaqSystem_consts.svh"

module DaqSystemTb
    import DaqDataPkg::*;
();

    localparam int WaitLimit   = 200;
    localparam int SelPower    = 0;
    localparam int SelResetB   = 1;
    localparam int SelStartAcq = 2;
    localparam int SelOnceEnd  = 3;
    localparam int SelAllDone  = 4;

    logic       Clk, arstN, DaqSelect, UsbAcqStart, ExternalTrigger, ChipSatB, ChipHit;
    CycleCountT CycleCount;
    logic       PwrOnA, PwrOnD, PwrOnAdc, PwrOnDac, ResetB, StartAcq;
    EventWordT  DataWord;
    logic       DataValid, OnceEnd, AllDone, UsbStartStop;
    logic       powerAll, powerAny, acqPrev;
    logic       slaveRun;
    logic [31:0] rngState;
    HitCountT   hitExpected;
    SerialT     serialExpected;
    EventWordT  wordExpected;
    int         wordCount, onceEndCount, cycles, words0, ends0;

    assign powerAll = PwrOnA & PwrOnD & PwrOnAdc & PwrOnDac;
    assign powerAny = PwrOnA | PwrOnD | PwrOnAdc | PwrOnDac;

    DaqSystem i_DaqSystem (.*);

    bind DaqSystem DaqSystem_assertions i_DaqSystemAssertions (
        .Clk(Clk), .arstN(arstN), .PwrOnA(PwrOnA), .PwrOnD(PwrOnD),
        .PwrOnAdc(PwrOnAdc), .PwrOnDac(PwrOnDac), .StartAcq(StartAcq),
        .DataValid(DataValid), .OnceEnd(OnceEnd), .UsbStartStop(UsbStartStop)
    );

    always #4 Clk = ~Clk;

    function automatic logic [31:0] nextRandom(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Serial on top, hit count below
    function automatic EventWordT expectedWord(input SerialT serial, input HitCountT hits);
        return {serial, hits};
    endfunction

    function automatic logic signalValue(input int sel);
        case (sel)
            SelPower:    return powerAll;
            SelResetB:   return ResetB;
            SelStartAcq: return StartAcq;
            SelOnceEnd:  return OnceEnd;
            SelAllDone:  return AllDone;
            default:     return 1'bx;
        endcase
    endfunction

    task automatic reportFailure(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkValue(input string name, input int got, input int exp);
        assert (got == exp) else begin
            reportFailure($sformatf("FAILED at %0t: %s got %0d, expected %0d",
                                    $time, name, got, exp));
        end
    endtask

    // Returns the falling edges passed until the level shows up
    task automatic waitLevel(input int sel, input logic level, input string what,
                             output int n);
        n = 0;
        while (signalValue(sel) !== level) begin
            @(negedge Clk);
            n++;
            if (n > WaitLimit) begin
                reportFailure($sformatf("Timeout after %0d cycles waiting for %s",
                                        WaitLimit, what));
            end
        end
    endtask

    task automatic pulseTrigger();
        ExternalTrigger = 1'b1;
        @(negedge Clk);
        ExternalTrigger = 1'b0;
    endtask

    task automatic checkIdle(input int count);
        repeat (count) begin
            @(negedge Clk);
            checkValue("StartAcq", int'(StartAcq), 0);
            checkValue("UsbStartStop", int'(UsbStartStop), 0);
        end
    endtask

    // No cycle may start on its own after OnceEnd
    task automatic checkNoCycle(input int count);
        repeat (count) begin
            @(negedge Clk);
            checkValue("ResetB", int'(ResetB), 1);
            checkValue("StartAcq", int'(StartAcq), 0);
        end
    endtask

    // One power pulsed cycle with the full window
    task automatic checkAutoCycle();
        int n;
        waitLevel(SelPower, 1'b1, "power up", n);
        waitLevel(SelResetB, 1'b0, "ResetB low", n);
        checkValue("power to ResetB cycles", n, `PWR_SETTLE);
        waitLevel(SelResetB, 1'b1, "ResetB release", n);
        checkValue("ResetB low cycles", n, `RESET_CYCLES);
        checkValue("StartAcq", int'(StartAcq), 1);
        waitLevel(SelStartAcq, 1'b0, "end of window", n);
        checkValue("StartAcq window cycles", n, `ACQ_WINDOW);
        waitLevel(SelOnceEnd, 1'b1, "OnceEnd", n);
        checkValue("PwrOn outputs between cycles", int'(powerAny), 0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Hit stimulus and expected count
    //////////////////////////////////////////////////////////////////////
    always @(negedge Clk) begin
        rngState = nextRandom(rngState);
        ChipHit  = rngState[0];
        if (StartAcq && !acqPrev) begin
            hitExpected = HitCountT'(ChipHit);
        end else if (StartAcq && ChipHit && hitExpected != '1) begin
            hitExpected = hitExpected + HitCountT'(1);
        end
        acqPrev = StartAcq;
    end

    // Word comparison
    always @(negedge Clk) begin
        if (arstN && DataValid) begin
            wordExpected = expectedWord(serialExpected, hitExpected);
            assert (DataWord === wordExpected) else begin
                reportFailure($sformatf("FAILED at %0t: DataWord got %h, expected %h",
                                        $time, DataWord, wordExpected));
            end
            serialExpected = serialExpected + SerialT'(1);
            wordCount++;
        end
    end

    // OnceEnd count and slave power between triggers
    always @(negedge Clk) begin
        if (arstN && OnceEnd) begin
            onceEndCount++;
        end
        if (slaveRun) begin
            assert (powerAll) else begin
                reportFailure($sformatf("FAILED at %0t: PwrOn outputs got %b, expected 1111",
                                        $time, {PwrOnA, PwrOnD, PwrOnAdc, PwrOnDac}));
            end
            assert (UsbStartStop) else begin
                reportFailure($sformatf("FAILED at %0t: UsbStartStop got %b, expected 1",
                                        $time, UsbStartStop));
            end
        end
    end

    initial begin
        Clk             = 1'b0;
        arstN           = 1'b0;
        DaqSelect       = 1'b1;
        UsbAcqStart     = 1'b0;
        CycleCount      = '0;
        ExternalTrigger = 1'b0;
        ChipSatB        = 1'b1;
        ChipHit         = 1'b0;
        rngState        = 32'h2523c573;
        acqPrev         = 1'b0;
        slaveRun        = 1'b0;
        hitExpected     = '0;
        serialExpected  = '0;
        wordCount       = 0;
        onceEndCount    = 0;
        repeat (4) @(posedge Clk);
        @(negedge Clk);
        arstN = 1'b1;

        // Auto run of three full cycles
        CycleCount  = CycleCountT'(3);
        UsbAcqStart = 1'b1;
        repeat (3) checkAutoCycle();
        waitLevel(SelAllDone, 1'b1, "AllDone", cycles);
        checkValue("UsbStartStop", int'(UsbStartStop), 0);
        checkValue("OnceEnd count", onceEndCount, 3);
        checkValue("word count", wordCount, 3);
        UsbAcqStart = 1'b0;

        // Saturation ends the window early
        @(negedge Clk);
        CycleCount  = CycleCountT'(1);
        UsbAcqStart = 1'b1;
        waitLevel(SelStartAcq, 1'b1, "StartAcq", cycles);
        repeat (10) @(negedge Clk);
        ChipSatB = 1'b0;
        waitLevel(SelStartAcq, 1'b0, "window end on saturation", cycles);
        checkValue("StartAcq cycles after saturation", cycles, 1);
        ChipSatB = 1'b1;
        waitLevel(SelAllDone, 1'b1, "AllDone", cycles);
        checkValue("word count", wordCount, 4);
        UsbAcqStart = 1'b0;

        // Stop request in the first of five cycles
        @(negedge Clk);
        ends0       = onceEndCount;
        CycleCount  = CycleCountT'(5);
        UsbAcqStart = 1'b1;
        waitLevel(SelStartAcq, 1'b1, "StartAcq", cycles);
        UsbAcqStart = 1'b0;
        waitLevel(SelAllDone, 1'b1, "AllDone after stop", cycles);
        checkValue("UsbStartStop", int'(UsbStartStop), 0);
        checkValue("OnceEnd count", onceEndCount - ends0, 1);
        checkValue("word count", wordCount, 5);

        // Trigger has no effect in auto mode
        pulseTrigger();
        checkIdle(2 * `ACQ_WINDOW);
        checkValue("word count", wordCount, 5);

        //////////////////////////////////////////////////////////////////////
        // Slave mode
        //////////////////////////////////////////////////////////////////////
        DaqSelect   = 1'b0;
        UsbAcqStart = 1'b1;
        waitLevel(SelPower, 1'b1, "slave power up", cycles);
        slaveRun = 1'b1;
        repeat (3) begin
            words0 = wordCount;
            pulseTrigger();
            waitLevel(SelStartAcq, 1'b1, "slave StartAcq", cycles);
            // Extra trigger inside the running cycle
            pulseTrigger();
            waitLevel(SelOnceEnd, 1'b1, "slave OnceEnd", cycles);
            checkValue("words per trigger", wordCount - words0, 1);
            // The extra trigger must not leave a cycle behind
            checkNoCycle(`RESET_CYCLES + 2);
        end

        // Stop while a slave cycle runs
        ends0 = onceEndCount;
        pulseTrigger();
        waitLevel(SelStartAcq, 1'b1, "slave StartAcq", cycles);
        UsbAcqStart = 1'b0;
        slaveRun    = 1'b0;
        waitLevel(SelAllDone, 1'b1, "slave AllDone", cycles);
        checkValue("UsbStartStop", int'(UsbStartStop), 0);
        checkValue("PwrOn outputs after stop", int'(powerAny), 0);
        checkValue("OnceEnd count", onceEndCount - ends0, 1);
        checkValue("word count", wordCount, 9);

        $display("No errors");
        $finish;
    end

endmodule

// File: verification/DaqSystem_assertions.sv
`timescale 1ns/1ps

module DaqSystem_assertions (
    input logic Clk,
    input logic arstN,
    input logic PwrOnA,
    input logic PwrOnD,
    input logic PwrOnAdc,
    input logic PwrOnDac,
    input logic StartAcq,
    input logic DataValid,
    input logic OnceEnd,
    input logic UsbStartStop
);

    // Chip fully powered during the acquisition window
    acqPowered: assert property (@(posedge Clk) disable iff (!arstN)
        StartAcq |-> (PwrOnA && PwrOnD && PwrOnAdc && PwrOnDac))
        else $error("StartAcq high while a power output is low");

    // One word per readout
    singleWord: assert property (@(posedge Clk) disable iff (!arstN)
        DataValid |=> !DataValid)
        else $error("DataValid high on two cycles in a row");

    // Cycle ends only inside a run
    endInRun: assert property (@(posedge Clk) disable iff (!arstN)
        OnceEnd |-> UsbStartStop)
        else $error("OnceEnd pulse outside a run");

endmodule
